/* Makefile */
# Verilator build and run of the rv64i core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(wildcard include/*.svh verilog/*.sv verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/rv_settings.svh */
// widths, ALU codes and branch codes of the rv64i pipeline, included by the package and the stages
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN 64
`define RV_NREG 32

`define RV_ALU_ADD   4'd0
`define RV_ALU_SUB   4'd1
`define RV_ALU_SLT   4'd2
`define RV_ALU_SLTU  4'd3
`define RV_ALU_XOR   4'd4
`define RV_ALU_OR    4'd5
`define RV_ALU_AND   4'd6
`define RV_ALU_SLL   4'd7
`define RV_ALU_SRL   4'd8
`define RV_ALU_SRA   4'd9
`define RV_ALU_COPYB 4'd10  // lui

`define RV_BR_NONE 4'd0
`define RV_BR_JAL  4'd1
`define RV_BR_JALR 4'd2
`define RV_BR_EQ   4'd3
`define RV_BR_NE   4'd4
`define RV_BR_LT   4'd5
`define RV_BR_GE   4'd6
`define RV_BR_LTU  4'd7
`define RV_BR_GEU  4'd8

// ALU input B sources
`define RV_BSRC_RS2  2'd0
`define RV_BSRC_IMM  2'd1
`define RV_BSRC_FOUR 2'd2  // return address pc + 4

`endif

/* tb.f */
+incdir+include
verilog/rv_pkg.sv
verilog/rv_pipe_if.sv
verilog/rv_gpr.sv
verilog/rv_alu.sv
verilog/rv_idu.sv
verilog/rv_exu.sv
verilog/rv_core.sv
verif/rv_core_tb.sv

/* verif/rv_core_tb.sv */
// directed testbench for the rv64i pipeline core, compiled with the RTL from tb.f
module rv_core_tb;

  localparam int RST_CYCLES   = 16;
  localparam int MAX_INSTS    = 200;  // all tests together issue fewer
  localparam int N_TESTS      = 6;
  localparam int DRAIN_CYCLES = 8;
  localparam int CYCLE_LIMIT  = RST_CYCLES + MAX_INSTS + N_TESTS * (DRAIN_CYCLES + 4) + 20;

  typedef struct packed {
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        wen;
    logic [63:0] data;
    logic        br;     // target only compared for branches and jumps
    logic        taken;
    logic [63:0] target;
    logic        inv;
    int          cyc;
  } ret_t;

  logic        clk;
  logic        i_rst_n;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic        o_ret_valid;
  logic [63:0] o_ret_pc;
  logic [4:0]  o_ret_rd;
  logic        o_ret_wen;
  logic [63:0] o_ret_data;
  logic        o_br_taken;
  logic [63:0] o_br_target;
  logic        o_ret_invalid;

  ret_t        exp_q [$];
  ret_t        head;
  logic [63:0] regs [32];  // architectural model
  logic [63:0] pc;
  int          cycles = 0;
  int          checks;
  int          errors;
  int          seq_errs;
  int          base_checks;
  int          base_errs;
  int          ntests;
  integer      seed;
  string       cur_test;

  rv_core rv_core_inst (
    .i_clk         (clk),
    .i_rst_n       (i_rst_n),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .o_ret_valid   (o_ret_valid),
    .o_ret_pc      (o_ret_pc),
    .o_ret_rd      (o_ret_rd),
    .o_ret_wen     (o_ret_wen),
    .o_ret_data    (o_ret_data),
    .o_br_taken    (o_br_taken),
    .o_br_target   (o_br_target),
    .o_ret_invalid (o_ret_invalid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    while (cycles < CYCLE_LIMIT) @(posedge clk);
    $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  // integer op semantics by funct3, alt selects sub and sra
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic word, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [31:0] r32;
    logic [63:0] r;
    r32 = 32'd0;
    r = 64'd0;
    if (word) begin
      case (f3)
        3'd0: r32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: r32 = a[31:0] << b[4:0];
        default: begin
          if (alt) r32 = $signed(a[31:0]) >>> b[4:0];
          else r32 = a[31:0] >> b[4:0];
        end
      endcase
      r = {{32{r32[31]}}, r32};
    end else begin
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'd0, $signed(a) < $signed(b)};
        3'd3: r = {63'd0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (alt) r = $signed(a) >>> b[5:0];
          else r = a >> b[5:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    return r;
  endfunction

  task automatic check_field(input string field, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      $display("ERROR %s %s expected %h actual %h", cur_test, field, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_record(input ret_t e);
    check_field("pc", e.pc, o_ret_pc);
    check_field("wen", 64'(e.wen), 64'(o_ret_wen));
    if (e.wen) begin
      check_field("rd", 64'(e.rd), 64'(o_ret_rd));
      check_field("data", e.data, o_ret_data);
    end
    check_field("taken", 64'(e.taken), 64'(o_br_taken));
    if (e.br) check_field("target", e.target, o_br_target);
    check_field("invalid", 64'(e.inv), 64'(o_ret_invalid));
    checks++;
    assert (cycles - e.cyc == 2) else begin
      $display("%s: pc %h retired %0d cycles after issue instead of 2",
               cur_test, e.pc, cycles - e.cyc);
      errors++;
    end
  endtask

  always @(negedge clk) begin
    if (i_rst_n && o_ret_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("%s: unexpected retirement at pc %h", cur_test, o_ret_pc);
        errors++;
      end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        check_record(head);
      end
    end
  end

  // drive one word, queue its record and update the model
  task automatic push(input logic [31:0] inst, input logic wen, input logic [63:0] data,
                      input logic br, input logic taken, input logic [63:0] target,
                      input logic inv);
    ret_t e;
    @(posedge clk);
    #1;
    i_inst_valid = 1'b1;
    i_inst = inst;
    i_pc = pc;
    e = '{pc, inst[11:7], wen, data, br, taken, target, inv, cycles};
    exp_q.push_back(e);
    if (wen && inst[11:7] != 5'd0) regs[inst[11:7]] = data;
    pc = pc + 64'd4;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    i_inst_valid = 1'b0;
    i_inst = 32'd0;
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic word, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
    logic        alt;
    logic [63:0] res;
    alt = (f3 == 3'd5) && imm[10];
    res = alu_ref(f3, alt, word, regs[rs1], {{52{imm[11]}}, imm});
    push(enc_i(imm, rs1, f3, rd, word ? 7'h1B : 7'h13), 1'b1, res, 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic op_reg(input logic [2:0] f3, input logic alt, input logic word,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [63:0] res;
    res = alu_ref(f3, alt, word, regs[rs1], regs[rs2]);
    push(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, word ? 7'h3B : 7'h33),
         1'b1, res, 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
    push({imm, rd, 7'h37}, 1'b1, {{32{imm[19]}}, imm, 12'h000}, 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic auipc(input logic [4:0] rd, input logic [19:0] imm);
    push({imm, rd, 7'h17}, 1'b1, pc + {{32{imm[19]}}, imm, 12'h000},
         1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic jal(input logic [4:0] rd, input logic [20:0] imm);
    push(enc_j(imm, rd), 1'b1, pc + 64'd4, 1'b1, 1'b1, pc + {{43{imm[20]}}, imm}, 1'b0);
  endtask

  task automatic jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [63:0] tgt;
    tgt = (regs[rs1] + {{52{imm[11]}}, imm}) & ~64'd1;
    push(enc_i(imm, rs1, 3'd0, rd, 7'h67), 1'b1, pc + 64'd4, 1'b1, 1'b1, tgt, 1'b0);
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic [12:0] imm);
    logic        t;
    logic [63:0] a;
    logic [63:0] b;
    a = regs[rs1];
    b = regs[rs2];
    case (f3)
      3'd0: t = (a == b);
      3'd1: t = (a != b);
      3'd4: t = ($signed(a) < $signed(b));
      3'd5: t = ($signed(a) >= $signed(b));
      3'd6: t = (a < b);
      default: t = (a >= b);
    endcase
    push(enc_b(imm, rs2, rs1, f3), 1'b0, 64'd0, 1'b1, t, pc + {{51{imm[12]}}, imm}, 1'b0);
  endtask

  task automatic load32(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;  // addiw adds a signed low part
    lui(rd, t[31:12]);
    op_imm(3'd0, 1'b1, rd, rd, v[11:0]);
  endtask

  task automatic load64(input logic [4:0] rd, input logic [4:0] tmp, input logic [63:0] v);
    load32(rd, v[63:32]);
    op_imm(3'd1, 1'b0, rd, rd, 12'd32);
    load32(tmp, v[31:0]);
    op_imm(3'd1, 1'b0, tmp, tmp, 12'd32);
    op_imm(3'd5, 1'b0, tmp, tmp, 12'd32);  // zero the upper half
    op_reg(3'd6, 1'b0, 1'b0, rd, rd, tmp);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    base_checks = checks;
    base_errs = errors + seq_errs;
  endtask

  task automatic finish_test();
    int n;
    idle();
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
      @(posedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d instructions never retired", cur_test, exp_q.size());
      seq_errs++;
      exp_q.delete();
    end
    repeat (2) @(posedge clk);
    $display("%-12s checks %0d errors %0d", cur_test, checks - base_checks,
             errors + seq_errs - base_errs);
    ntests++;
  endtask

  task automatic test_imm();
    start_test("imm_ops");
    lui(5'd1, 20'hFEDCB);
    op_imm(3'd0, 1'b0, 5'd2, 5'd1, 12'hEDD);
    op_imm(3'd2, 1'b0, 5'd3, 5'd2, 12'h005);
    op_imm(3'd3, 1'b0, 5'd4, 5'd2, 12'h005);
    op_imm(3'd3, 1'b0, 5'd5, 5'd0, 12'hFFF);
    op_imm(3'd4, 1'b0, 5'd6, 5'd2, 12'hFFF);
    op_imm(3'd6, 1'b0, 5'd7, 5'd2, 12'h0F0);
    op_imm(3'd7, 1'b0, 5'd8, 5'd2, 12'h7F0);
    op_imm(3'd1, 1'b0, 5'd9, 5'd2, 12'h028);
    op_imm(3'd5, 1'b0, 5'd10, 5'd2, 12'h00D);
    op_imm(3'd5, 1'b0, 5'd11, 5'd2, 12'h43F);  // srai 63
    op_imm(3'd5, 1'b0, 5'd12, 5'd9, 12'h404);
    auipc(5'd13, 20'h12345);
    auipc(5'd14, 20'hFFFFF);
    lui(5'd15, 20'h7FFFF);
    finish_test();
  endtask

  task automatic test_reg();
    logic [2:0]  rr_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic        rr_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic [63:0] va;
    logic [63:0] vb;
    start_test("reg_ops");
    for (int r = 0; r < 2; r++) begin
      va = {32'($random(seed)), 32'($random(seed))};
      vb = {32'($random(seed)), 32'($random(seed))};
      load64(5'd20, 5'd22, va);
      load64(5'd21, 5'd22, vb);
      for (int i = 0; i < 10; i++) begin
        op_reg(rr_f3[i], rr_alt[i], 1'b0, 5'(10 + i), 5'd20, 5'd21);
      end
    end
    finish_test();
  endtask

  task automatic test_word();
    start_test("word_ops");
    load64(5'd20, 5'd22, 64'h1234_5678_7FFF_FFFF);
    load64(5'd21, 5'd22, 64'hFFFF_0000_0000_0001);
    op_reg(3'd0, 1'b0, 1'b1, 5'd10, 5'd20, 5'd21);  // addw overflows into bit 31
    op_reg(3'd0, 1'b1, 1'b1, 5'd11, 5'd20, 5'd21);
    op_reg(3'd1, 1'b0, 1'b1, 5'd12, 5'd21, 5'd20);
    op_reg(3'd5, 1'b0, 1'b1, 5'd13, 5'd20, 5'd21);
    op_reg(3'd5, 1'b1, 1'b1, 5'd14, 5'd12, 5'd21);
    op_imm(3'd5, 1'b1, 5'd15, 5'd12, 12'h408);  // sraiw 8
    op_imm(3'd5, 1'b1, 5'd16, 5'd12, 12'h008);
    op_imm(3'd1, 1'b1, 5'd17, 5'd20, 12'h004);
    op_imm(3'd0, 1'b1, 5'd18, 5'd20, 12'h001);
    op_imm(3'd0, 1'b1, 5'd19, 5'd21, 12'hFFE);
    finish_test();
  endtask

  task automatic test_fwd();
    start_test("forwarding");
    op_imm(3'd0, 1'b0, 5'd10, 5'd0, 12'h123);
    op_imm(3'd0, 1'b0, 5'd11, 5'd10, 12'h001);
    op_reg(3'd0, 1'b0, 1'b0, 5'd12, 5'd10, 5'd11);
    op_reg(3'd0, 1'b1, 1'b0, 5'd13, 5'd10, 5'd11);
    op_reg(3'd4, 1'b0, 1'b0, 5'd14, 5'd10, 5'd12);
    op_imm(3'd0, 1'b0, 5'd0, 5'd10, 12'h055);  // x0 stays zero
    op_reg(3'd0, 1'b0, 1'b0, 5'd15, 5'd0, 5'd0);
    op_reg(3'd0, 1'b0, 1'b0, 5'd16, 5'd0, 5'd10);
    op_imm(3'd0, 1'b0, 5'd17, 5'd0, 12'h001);
    op_imm(3'd0, 1'b0, 5'd17, 5'd17, 12'h001);
    op_imm(3'd0, 1'b0, 5'd17, 5'd17, 12'h001);
    op_imm(3'd0, 1'b0, 5'd18, 5'd0, 12'h200);
    idle();
    op_imm(3'd0, 1'b0, 5'd19, 5'd18, 12'h003);
    op_imm(3'd0, 1'b0, 5'd20, 5'd0, 12'h300);
    idle();
    idle();
    op_imm(3'd0, 1'b0, 5'd21, 5'd20, 12'h004);
    op_reg(3'd0, 1'b0, 1'b0, 5'd22, 5'd17, 5'd19);
    finish_test();
  endtask

  task automatic test_branch();
    logic [2:0] cond_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    start_test("branches");
    op_imm(3'd0, 1'b0, 5'd1, 5'd0, 12'h005);
    op_imm(3'd0, 1'b0, 5'd2, 5'd0, 12'hFFD);
    op_imm(3'd0, 1'b0, 5'd3, 5'd0, 12'h005);
    for (int i = 0; i < 6; i++) begin
      branch(cond_f3[i], 5'd1, 5'd3, 13'h1FF0);
      branch(cond_f3[i], 5'd1, 5'd2, 13'h0124);
      branch(cond_f3[i], 5'd2, 5'd1, 13'h0008);
    end
    jal(5'd5, 21'h000F0);
    jal(5'd6, 21'h1FFF00);
    op_imm(3'd0, 1'b0, 5'd7, 5'd0, 12'h101);
    jalr(5'd8, 5'd7, 12'h010);  // odd sum, bit 0 dropped
    jalr(5'd9, 5'd5, 12'hFFF);
    jalr(5'd7, 5'd7, 12'h001);
    finish_test();
  endtask

  task automatic test_invalid();
    start_test("unsupported");
    op_imm(3'd0, 1'b0, 5'd5, 5'd0, 12'h02A);
    push(enc_i(12'h008, 5'd0, 3'd3, 5'd5, 7'h03), 1'b0, 64'd0, 1'b0, 1'b0, 64'd0, 1'b1);
    push(32'h0000_0073, 1'b0, 64'd0, 1'b0, 1'b0, 64'd0, 1'b1);
    push(enc_r(7'h01, 5'd5, 5'd5, 3'd0, 5'd5, 7'h33), 1'b0, 64'd0, 1'b0, 1'b0, 64'd0, 1'b1);
    push(32'd0, 1'b0, 64'd0, 1'b0, 1'b0, 64'd0, 1'b0);  // bubble word
    op_imm(3'd0, 1'b0, 5'd6, 5'd5, 12'h000);
    finish_test();
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_inst_valid = 1'b0;
    i_inst = 32'd0;
    i_pc = 64'd0;
    pc = 64'h0000_0000_0000_1000;
    seed = 66;
    checks = 0;
    errors = 0;
    seq_errs = 0;
    ntests = 0;
    cur_test = "reset";
    for (int i = 0; i < 32; i++) regs[i] = 64'd0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 i_rst_n = 1'b1;
    assert (o_ret_valid === 1'b0 && o_ret_wen === 1'b0 && o_br_taken === 1'b0 &&
            o_ret_invalid === 1'b0) else begin
      $display("retirement outputs not cleared by reset");
      seq_errs++;
    end
    test_imm();
    test_reg();
    test_word();
    test_fwd();
    test_branch();
    test_invalid();
    $display("tests %0d checks %0d errors %0d", ntests, checks, errors + seq_errs);
    if (errors + seq_errs == 0) $display("TEST PASSED");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

/* verilog/rv_alu.sv */
// combinational 64-bit ALU of the execute stage, with 32-bit word mode for the W instructions
`include "rv_settings.svh"

module rv_alu (
  input  rv_pkg::xlen_t   i_a,
  input  rv_pkg::xlen_t   i_b,
  input  rv_pkg::alu_op_t i_op,
  input  logic            i_word_cut,
  output rv_pkg::xlen_t   o_result
);

  rv_pkg::xlen_t a_w;
  rv_pkg::xlen_t b_w;
  rv_pkg::xlen_t res;
  logic [5:0]    shamt;

  // upper half of A filled so that right shifts see a 32-bit operand
  assign a_w = i_word_cut ? {{(`RV_XLEN-32){i_a[31] & (i_op == `RV_ALU_SRA)}}, i_a[31:0]}
                          : i_a;
  assign b_w = i_word_cut ? {{(`RV_XLEN-32){1'b0}}, i_b[31:0]} : i_b;

  assign shamt = i_word_cut ? {1'b0, i_b[4:0]} : i_b[5:0];

  always_comb begin
    case (i_op)
      `RV_ALU_ADD:   res = a_w + b_w;
      `RV_ALU_SUB:   res = a_w - b_w;
      `RV_ALU_SLT:   res = {{(`RV_XLEN-1){1'b0}}, $signed(a_w) < $signed(b_w)};
      `RV_ALU_SLTU:  res = {{(`RV_XLEN-1){1'b0}}, a_w < b_w};
      `RV_ALU_XOR:   res = a_w ^ b_w;
      `RV_ALU_OR:    res = a_w | b_w;
      `RV_ALU_AND:   res = a_w & b_w;
      `RV_ALU_SLL:   res = a_w << shamt;
      `RV_ALU_SRL:   res = a_w >> shamt;
      `RV_ALU_SRA:   res = $signed(a_w) >>> shamt;
      `RV_ALU_COPYB: res = i_b;  // lui
      default:       res = '0;
    endcase
  end

  // W results are sign extended from bit 31
  assign o_result = i_word_cut ? {{(`RV_XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

/* verilog/rv_core.sv */
// top of the three-stage rv64i pipeline, feeds instructions in and reports each retirement
module rv_core (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_inst_valid,
  input  rv_pkg::inst_t     i_inst,
  input  rv_pkg::xlen_t     i_pc,
  output logic              o_ret_valid,
  output rv_pkg::xlen_t     o_ret_pc,
  output rv_pkg::reg_addr_t o_ret_rd,
  output logic              o_ret_wen,
  output rv_pkg::xlen_t     o_ret_data,
  output logic              o_br_taken,
  output rv_pkg::xlen_t     o_br_target,
  output logic              o_ret_invalid
);

  dec_if u_dec ();
  fwd_if u_fwd ();
  wb_if  u_wb ();

  rv_idu u_idu (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .i_fwd        (u_fwd.idu),
    .i_wb         (u_wb.gpr),
    .o_dec        (u_dec.idu)
  );

  rv_exu u_exu (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_dec   (u_dec.exu),
    .o_fwd   (u_fwd.exu),
    .o_wb    (u_wb.exu)
  );

  // retirement record straight from the execute register
  assign o_ret_valid   = u_wb.valid;
  assign o_ret_pc      = u_wb.pc;
  assign o_ret_rd      = u_wb.rd;
  assign o_ret_wen     = u_wb.reg_wr;
  assign o_ret_data    = u_wb.data;
  assign o_br_taken    = u_wb.br_taken;
  assign o_br_target   = u_wb.br_target;
  assign o_ret_invalid = u_wb.invalid;

endmodule

/* verilog/rv_exu.sv */
// execute stage, runs the ALU and branch compare, forwards the result and registers retirement
`include "rv_settings.svh"

module rv_exu (
  input  logic  i_clk,
  input  logic  i_rst_n,
  dec_if.exu    i_dec,
  fwd_if.exu    o_fwd,
  wb_if.exu     o_wb
);

  rv_pkg::xlen_t alu_a;
  rv_pkg::xlen_t alu_b;
  rv_pkg::xlen_t result;
  rv_pkg::xlen_t target;
  logic          taken;

  assign alu_a = i_dec.a_src ? i_dec.pc : i_dec.rs1_val;

  always_comb begin
    case (i_dec.b_src)
      `RV_BSRC_IMM:  alu_b = i_dec.imm;
      `RV_BSRC_FOUR: alu_b = rv_pkg::xlen_t'(4);
      default:       alu_b = i_dec.rs2_val;
    endcase
  end

  rv_alu u_alu (
    .i_a        (alu_a),
    .i_b        (alu_b),
    .i_op       (i_dec.alu_op),
    .i_word_cut (i_dec.word_cut),
    .o_result   (result)
  );

  wire eq  = (i_dec.rs1_val == i_dec.rs2_val);
  wire lt  = ($signed(i_dec.rs1_val) < $signed(i_dec.rs2_val));
  wire ltu = (i_dec.rs1_val < i_dec.rs2_val);

  always_comb begin
    case (i_dec.br_op)
      `RV_BR_JAL, `RV_BR_JALR: taken = 1'b1;
      `RV_BR_EQ:  taken = eq;
      `RV_BR_NE:  taken = ~eq;
      `RV_BR_LT:  taken = lt;
      `RV_BR_GE:  taken = ~lt;
      `RV_BR_LTU: taken = ltu;
      `RV_BR_GEU: taken = ~ltu;
      default:    taken = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign target = (i_dec.br_op == `RV_BR_JALR) ?
                  ((i_dec.rs1_val + i_dec.imm) & ~rv_pkg::xlen_t'(1)) : (i_dec.pc + i_dec.imm);

  assign o_fwd.valid  = i_dec.valid;
  assign o_fwd.rd     = i_dec.rd;
  assign o_fwd.reg_wr = i_dec.reg_wr;
  assign o_fwd.data   = result;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb.valid    <= 1'b0;
      o_wb.reg_wr   <= 1'b0;
      o_wb.br_taken <= 1'b0;
      o_wb.invalid  <= 1'b0;
    end else begin
      o_wb.valid    <= i_dec.valid;
      o_wb.reg_wr   <= i_dec.valid & i_dec.reg_wr;
      o_wb.br_taken <= i_dec.valid & taken;
      o_wb.invalid  <= i_dec.valid & i_dec.invalid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb.pc        <= i_dec.pc;
    o_wb.rd        <= i_dec.rd;
    o_wb.data      <= result;
    o_wb.br_target <= target;
  end

endmodule

/* verilog/rv_gpr.sv */
// integer register file with write-through bypass, instantiated inside the decode stage
`include "rv_settings.svh"

module rv_gpr (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  rv_pkg::reg_addr_t i_ra,
  input  rv_pkg::reg_addr_t i_rb,
  output rv_pkg::xlen_t     o_bus_a,
  output rv_pkg::xlen_t     o_bus_b,
  wb_if.gpr                 i_wb
);

  rv_pkg::xlen_t regs [`RV_NREG];

  // x0 never written
  wire wr_en = i_wb.valid & i_wb.reg_wr & (i_wb.rd != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // write-through for the instruction two slots ahead
  assign o_bus_a = (wr_en && (i_wb.rd == i_ra)) ? i_wb.data : regs[i_ra];
  assign o_bus_b = (wr_en && (i_wb.rd == i_rb)) ? i_wb.data : regs[i_rb];

endmodule

/* verilog/rv_idu.sv */
// decode stage, decodes the incoming word, reads and forwards operands, registers into execute
`include "rv_settings.svh"

module rv_idu (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_inst_valid,
  input  rv_pkg::inst_t  i_inst,
  input  rv_pkg::xlen_t  i_pc,
  fwd_if.idu             i_fwd,
  wb_if.gpr              i_wb,
  dec_if.idu             o_dec
);

  wire [6:0] opcode = i_inst[6:0];
  wire [2:0] funct3 = i_inst[14:12];
  wire [6:0] funct7 = i_inst[31:25];
  wire rv_pkg::reg_addr_t ra = i_inst[19:15];
  wire rv_pkg::reg_addr_t rb = i_inst[24:20];
  wire rv_pkg::reg_addr_t rd = i_inst[11:7];

  wire rv_pkg::xlen_t imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  wire rv_pkg::xlen_t imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  wire rv_pkg::xlen_t imm_b = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                               i_inst[11:8], 1'b0};
  wire rv_pkg::xlen_t imm_j = {{(`RV_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                               i_inst[30:21], 1'b0};

  wire op_imm   = (opcode == 7'b0010011);
  wire op_reg   = (opcode == 7'b0110011);
  wire op_imm32 = (opcode == 7'b0011011);
  wire op_reg32 = (opcode == 7'b0111011);
  wire op_br    = (opcode == 7'b1100011);
  wire f7_zero  = (funct7 == 7'b0000000);
  wire f7_alt   = (funct7 == 7'b0100000);

  wire inst_lui   = (opcode == 7'b0110111);
  wire inst_auipc = (opcode == 7'b0010111);
  wire inst_jal   = (opcode == 7'b1101111);
  wire inst_jalr  = (opcode == 7'b1100111) & (funct3 == 3'b000);
  wire inst_beq   = op_br & (funct3 == 3'b000);
  wire inst_bne   = op_br & (funct3 == 3'b001);
  wire inst_blt   = op_br & (funct3 == 3'b100);
  wire inst_bge   = op_br & (funct3 == 3'b101);
  wire inst_bltu  = op_br & (funct3 == 3'b110);
  wire inst_bgeu  = op_br & (funct3 == 3'b111);
  wire inst_addi  = op_imm & (funct3 == 3'b000);
  wire inst_slti  = op_imm & (funct3 == 3'b010);
  wire inst_sltiu = op_imm & (funct3 == 3'b011);
  wire inst_xori  = op_imm & (funct3 == 3'b100);
  wire inst_ori   = op_imm & (funct3 == 3'b110);
  wire inst_andi  = op_imm & (funct3 == 3'b111);
  wire inst_slli  = op_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b000000);  // 6-bit shamt
  wire inst_srli  = op_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b000000);
  wire inst_srai  = op_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b010000);
  wire inst_add   = op_reg & (funct3 == 3'b000) & f7_zero;
  wire inst_sub   = op_reg & (funct3 == 3'b000) & f7_alt;
  wire inst_sll   = op_reg & (funct3 == 3'b001) & f7_zero;
  wire inst_slt   = op_reg & (funct3 == 3'b010) & f7_zero;
  wire inst_sltu  = op_reg & (funct3 == 3'b011) & f7_zero;
  wire inst_xor   = op_reg & (funct3 == 3'b100) & f7_zero;
  wire inst_srl   = op_reg & (funct3 == 3'b101) & f7_zero;
  wire inst_sra   = op_reg & (funct3 == 3'b101) & f7_alt;
  wire inst_or    = op_reg & (funct3 == 3'b110) & f7_zero;
  wire inst_and   = op_reg & (funct3 == 3'b111) & f7_zero;
  wire inst_addiw = op_imm32 & (funct3 == 3'b000);
  wire inst_slliw = op_imm32 & (funct3 == 3'b001) & f7_zero;
  wire inst_srliw = op_imm32 & (funct3 == 3'b101) & f7_zero;
  wire inst_sraiw = op_imm32 & (funct3 == 3'b101) & f7_alt;
  wire inst_addw  = op_reg32 & (funct3 == 3'b000) & f7_zero;
  wire inst_subw  = op_reg32 & (funct3 == 3'b000) & f7_alt;
  wire inst_sllw  = op_reg32 & (funct3 == 3'b001) & f7_zero;
  wire inst_srlw  = op_reg32 & (funct3 == 3'b101) & f7_zero;
  wire inst_sraw  = op_reg32 & (funct3 == 3'b101) & f7_alt;

  wire type_r = |{inst_add, inst_sub, inst_sll, inst_slt, inst_sltu, inst_xor, inst_srl,
                  inst_sra, inst_or, inst_and, inst_addw, inst_subw, inst_sllw, inst_srlw,
                  inst_sraw};
  wire type_i = |{inst_jalr, inst_addi, inst_slti, inst_sltiu, inst_xori, inst_ori, inst_andi,
                  inst_slli, inst_srli, inst_srai, inst_addiw, inst_slliw, inst_srliw,
                  inst_sraiw};
  wire type_u = inst_lui | inst_auipc;
  wire type_b = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};

  wire supported = type_r | type_i | type_u | type_b | inst_jal;
  wire reg_wr    = supported & ~type_b;
  wire invalid   = ~supported & (i_inst != '0);  // zero word is a bubble
  wire word_cut  = op_imm32 | op_reg32;
  wire a_src     = inst_auipc | inst_jal | inst_jalr;

  rv_pkg::xlen_t   imm;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::br_op_t  br_op;
  rv_pkg::bsrc_t   b_src;

  always_comb begin
    imm = imm_i;
    if (type_u)        imm = imm_u;
    else if (type_b)   imm = imm_b;
    else if (inst_jal) imm = imm_j;
  end

  always_comb begin
    alu_op = `RV_ALU_ADD;  // also auipc, jal, jalr
    if (inst_lui)                                 alu_op = `RV_ALU_COPYB;
    else if (inst_sub | inst_subw)                alu_op = `RV_ALU_SUB;
    else if (inst_slt | inst_slti)                alu_op = `RV_ALU_SLT;
    else if (inst_sltu | inst_sltiu)              alu_op = `RV_ALU_SLTU;
    else if (inst_xor | inst_xori)                alu_op = `RV_ALU_XOR;
    else if (inst_or | inst_ori)                  alu_op = `RV_ALU_OR;
    else if (inst_and | inst_andi)                alu_op = `RV_ALU_AND;
    else if (|{inst_sll, inst_slli, inst_sllw, inst_slliw}) alu_op = `RV_ALU_SLL;
    else if (|{inst_srl, inst_srli, inst_srlw, inst_srliw}) alu_op = `RV_ALU_SRL;
    else if (|{inst_sra, inst_srai, inst_sraw, inst_sraiw}) alu_op = `RV_ALU_SRA;
  end

  always_comb begin
    br_op = `RV_BR_NONE;
    if (inst_jal)       br_op = `RV_BR_JAL;
    else if (inst_jalr) br_op = `RV_BR_JALR;
    else if (inst_beq)  br_op = `RV_BR_EQ;
    else if (inst_bne)  br_op = `RV_BR_NE;
    else if (inst_blt)  br_op = `RV_BR_LT;
    else if (inst_bge)  br_op = `RV_BR_GE;
    else if (inst_bltu) br_op = `RV_BR_LTU;
    else if (inst_bgeu) br_op = `RV_BR_GEU;
  end

  always_comb begin
    b_src = `RV_BSRC_RS2;
    if (inst_jal | inst_jalr)  b_src = `RV_BSRC_FOUR;
    else if (type_i | type_u)  b_src = `RV_BSRC_IMM;
  end

  rv_pkg::xlen_t bus_a;
  rv_pkg::xlen_t bus_b;

  rv_gpr u_gprs (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ra    (ra),
    .i_rb    (rb),
    .o_bus_a (bus_a),
    .o_bus_b (bus_b),
    .i_wb    (i_wb)
  );

  // execute result wins over the register file path
  wire fwd_a = i_fwd.valid & i_fwd.reg_wr & (i_fwd.rd == ra) & (ra != '0);
  wire fwd_b = i_fwd.valid & i_fwd.reg_wr & (i_fwd.rd == rb) & (rb != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_dec.valid   <= 1'b0;
      o_dec.reg_wr  <= 1'b0;
      o_dec.invalid <= 1'b0;
    end else begin
      o_dec.valid   <= i_inst_valid;
      o_dec.reg_wr  <= i_inst_valid & reg_wr;
      o_dec.invalid <= i_inst_valid & invalid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_dec.pc       <= i_pc;
    o_dec.rs1_val  <= fwd_a ? i_fwd.data : bus_a;
    o_dec.rs2_val  <= fwd_b ? i_fwd.data : bus_b;
    o_dec.imm      <= imm;
    o_dec.alu_op   <= alu_op;
    o_dec.a_src    <= a_src;
    o_dec.b_src    <= b_src;
    o_dec.word_cut <= word_cut;
    o_dec.br_op    <= br_op;
    o_dec.rd       <= rd;
  end

endmodule

/* verilog/rv_pipe_if.sv */
// stage to stage interfaces of the pipeline, instantiated in the core and passed to the stages
interface dec_if;
  logic               valid;
  rv_pkg::xlen_t      pc;
  rv_pkg::xlen_t      rs1_val;
  rv_pkg::xlen_t      rs2_val;
  rv_pkg::xlen_t      imm;
  rv_pkg::alu_op_t    alu_op;
  logic               a_src;  // 1 selects pc
  rv_pkg::bsrc_t      b_src;
  logic               word_cut;
  rv_pkg::br_op_t     br_op;
  rv_pkg::reg_addr_t  rd;
  logic               reg_wr;
  logic               invalid;

  modport idu (output valid, pc, rs1_val, rs2_val, imm, alu_op, a_src, b_src, word_cut,
               br_op, rd, reg_wr, invalid);
  modport exu (input  valid, pc, rs1_val, rs2_val, imm, alu_op, a_src, b_src, word_cut,
               br_op, rd, reg_wr, invalid);
endinterface

// result of the instruction now in execute
interface fwd_if;
  logic               valid;
  rv_pkg::reg_addr_t  rd;
  logic               reg_wr;
  rv_pkg::xlen_t      data;

  modport exu (output valid, rd, reg_wr, data);
  modport idu (input  valid, rd, reg_wr, data);
endinterface

// registered retirement record
interface wb_if;
  logic               valid;
  rv_pkg::xlen_t      pc;
  rv_pkg::reg_addr_t  rd;
  logic               reg_wr;
  rv_pkg::xlen_t      data;
  logic               br_taken;
  rv_pkg::xlen_t      br_target;
  logic               invalid;

  modport exu (output valid, pc, rd, reg_wr, data, br_taken, br_target, invalid);
  modport gpr (input  valid, pc, rd, reg_wr, data, br_taken, br_target, invalid);
endinterface

/* verilog/rv_pkg.sv */
// vector types shared by every stage of the rv64i pipeline, referenced as rv_pkg::name
`include "rv_settings.svh"

package rv_pkg;

  // one register value or address
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // register index
  typedef logic [$clog2(`RV_NREG)-1:0] reg_addr_t;

  // ALU operation code
  typedef logic [3:0] alu_op_t;

  // branch condition code
  typedef logic [3:0] br_op_t;

  // ALU input B selector
  typedef logic [1:0] bsrc_t;

endpackage
